/* tb/golden_vectors.txt */
# W address data and R address expected_data are hex AXI writes and checked reads.
# P channel periods divider expected_active_cycles is decimal and counts pwm active cycles.
R 100 00000000
R 104 000186a0
R 108 0000c350
R 10c 00000080
R 200 00000000
R 204 000186a0
R 208 0000c350
R 20c 00000080
W 204 0000beef
W 208 00c0ffee
W 20c 00000055
W 100 fffffffc
R 100 fffffffc
R 200 00000000
W 104 00001234
R 104 00001234
R 204 0000beef
W 108 00000777
R 108 00000777
R 208 00c0ffee
W 10c 000000ab
R 10c 000000ab
R 20c 00000055
R 110 00000000
R 300 00000000
R 004 00000000
W 104 0000000a
W 108 00000004
W 10c 00000080
W 100 00000001
P 0 5 10 20
W 108 0000000f
P 0 5 10 50
W 204 00000014
W 208 00000008
W 20c 00000040
W 200 00000001
R 200 00000001
P 1 3 20 12
W 208 0000000c
W 20c 000000ff
P 1 3 20 60
W 108 00000004
W 100 00000003
P 0 5 10 20
W 100 00000002
P 0 5 10 0

/* sources.f */
design/periph_pkg.sv
design/axi_lite_slave.sv
design/pwm_generator.sv
design/pwm_regs.sv
design/periph_top.sv
tb/tb_periph_top.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log for the result.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ns --top-module tb_periph_top \
    -f sources.f -o tb_periph_top || { echo "Build failed"; exit 1; }
./obj_dir/tb_periph_top > sim.log 2>&1 || true
cat sim.log
grep -q "sim failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "sim passed" sim.log || { echo "FAIL: run ended without a result"; exit 1; }
echo "PASS"

/* tb/tb_periph_top.sv */
`timescale 1ns/1ns

module tb_periph_top;

    localparam int    CLK_PERIOD = 10;
    localparam string VEC_FILE   = "tb/golden_vectors.txt";

    logic                            S_AXI_ACLK;
    logic                            S_AXI_ARESETN;
    logic [periph_pkg::ADDR_W-1:0]   s_axi_awaddr;
    logic                            s_axi_awvalid;
    logic                            s_axi_awready;
    logic [periph_pkg::DATA_W-1:0]   s_axi_wdata;
    logic [periph_pkg::DATA_W/8-1:0] s_axi_wstrb;
    logic                            s_axi_wvalid;
    logic                            s_axi_wready;
    periph_pkg::axi_resp_t           s_axi_bresp;
    logic                            s_axi_bvalid;
    logic                            s_axi_bready;
    logic [periph_pkg::ADDR_W-1:0]   s_axi_araddr;
    logic                            s_axi_arvalid;
    logic                            s_axi_arready;
    logic [periph_pkg::DATA_W-1:0]   s_axi_rdata;
    periph_pkg::axi_resp_t           s_axi_rresp;
    logic                            s_axi_rvalid;
    logic                            s_axi_rready;
    logic                            pwm_out0;
    logic                            pwm_out1;
    logic                            polarity_of [2]; // Mode bit 1 of each channel as last written.
    string                           vectors [$];
    int                              watchdog_cycles = 0;

    periph_top #(
        .DATA_W (periph_pkg::DATA_W),
        .ADDR_W (periph_pkg::ADDR_W)
    ) dut (.*);

    initial begin
        S_AXI_ACLK = 1'b0;
        forever #(CLK_PERIOD / 2) S_AXI_ACLK = ~S_AXI_ACLK;
    end

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge S_AXI_ACLK);
        abort_run($sformatf("Timeout: the tests did not finish within %0d clock cycles.",
                            watchdog_cycles));
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1, "Testbench stopped at the first error.");
    endtask

    task automatic next_cycle();
        @(posedge S_AXI_ACLK);
        #1; // Inputs change and outputs are sampled just after the edge.
    endtask

    task automatic check_rdata(input string name, input logic [periph_pkg::DATA_W-1:0] expected,
                               input logic [periph_pkg::DATA_W-1:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("MISMATCH at %0t ns: %s expected 0x%08h, got 0x%08h",
                                $time, name, expected, actual));
        end
    endtask

    task automatic check_resp(input string name, input periph_pkg::axi_resp_t expected,
                              input periph_pkg::axi_resp_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("MISMATCH at %0t ns: %s expected %0d, got %0d",
                                $time, name, expected, actual));
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            abort_run($sformatf("MISMATCH at %0t ns: %s expected %0d, got %0d",
                                $time, name, expected, actual));
        end
    endtask

    task automatic axi_write(input logic [periph_pkg::ADDR_W-1:0] addr,
                             input logic [periph_pkg::DATA_W-1:0] data);
        s_axi_awaddr  = addr;
        s_axi_wdata   = data;
        s_axi_awvalid = 1'b1;
        s_axi_wvalid  = 1'b1;
        do begin
            next_cycle();
        end while (!(s_axi_awready && s_axi_wready));
        next_cycle(); // The handshake completes on this edge.
        s_axi_awvalid = 1'b0;
        s_axi_wvalid  = 1'b0;
        while (!s_axi_bvalid) begin
            next_cycle();
        end
        check_resp("s_axi_bresp", periph_pkg::RESP_OKAY, s_axi_bresp);
        next_cycle();
    endtask

    task automatic axi_read(input logic [periph_pkg::ADDR_W-1:0] addr,
                            input logic [periph_pkg::DATA_W-1:0] expected);
        s_axi_araddr  = addr;
        s_axi_arvalid = 1'b1;
        do begin
            next_cycle();
        end while (!s_axi_arready);
        next_cycle();
        s_axi_arvalid = 1'b0;
        while (!s_axi_rvalid) begin
            next_cycle();
        end
        check_rdata($sformatf("s_axi_rdata at 0x%03h", addr), expected, s_axi_rdata);
        check_resp("s_axi_rresp", periph_pkg::RESP_OKAY, s_axi_rresp);
        next_cycle();
    endtask

    // Counts cycles at the active level, which is the inverse of the channel polarity.
    task automatic measure_pwm(input int chan, input int periods, input int divider,
                               input int expected);
        int count;
        count = 0;
        repeat (2 * divider) @(posedge S_AXI_ACLK); // New settings reach the pin by now.
        repeat (periods * divider) begin
            next_cycle();
            if (((chan == 0) ? pwm_out0 : pwm_out1) === !polarity_of[chan[0]]) begin
                count = count + 1;
            end
        end
        check_count($sformatf("pwm_out%0d active cycles", chan), expected, count);
    endtask

    task automatic load_vectors();
        int    fd;
        int    budget;
        string line;
        int    chan;
        int    periods;
        int    divider;
        int    expected;
        budget = 100;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            abort_run($sformatf("Could not open the vector file %s.", VEC_FILE));
        end
        while ($fgets(line, fd) > 0) begin
            vectors.push_back(line);
            if ($sscanf(line, "P %d %d %d %d", chan, periods, divider, expected) == 4) begin
                budget += (periods + 2) * divider + 2;
            end else begin
                budget += 50;
            end
        end
        $fclose(fd);
        watchdog_cycles = budget;
    endtask

    task automatic run_vector(input string line);
        logic [periph_pkg::ADDR_W-1:0] addr;
        logic [periph_pkg::DATA_W-1:0] data;
        int                            chan;
        int                            periods;
        int                            divider;
        int                            expected;
        int                            fields;
        case (line.getc(0))
            "W": begin
                fields = $sscanf(line, "W %h %h", addr, data);
                if (fields != 2) abort_run($sformatf("Malformed write line: %s", line));
                if (addr[7:2] == periph_pkg::REG_MODE) begin
                    if (addr[11:8] == periph_pkg::PWM0_BASE) polarity_of[0] = data[1];
                    if (addr[11:8] == periph_pkg::PWM1_BASE) polarity_of[1] = data[1];
                end
                axi_write(addr, data);
            end
            "R": begin
                fields = $sscanf(line, "R %h %h", addr, data);
                if (fields != 2) abort_run($sformatf("Malformed read line: %s", line));
                axi_read(addr, data);
            end
            "P": begin
                fields = $sscanf(line, "P %d %d %d %d", chan, periods, divider, expected);
                if (fields != 4) abort_run($sformatf("Malformed PWM line: %s", line));
                measure_pwm(chan, periods, divider, expected);
            end
            "#", "\n", "\r", 8'd0: ;
            default: abort_run($sformatf("Unknown operation in vector line: %s", line));
        endcase
    endtask

    initial begin
        S_AXI_ARESETN  = 1'b0;
        s_axi_awaddr   = '0;
        s_axi_awvalid  = 1'b0;
        s_axi_wdata    = '0;
        s_axi_wstrb    = '1;
        s_axi_wvalid   = 1'b0;
        s_axi_bready   = 1'b1;
        s_axi_araddr   = '0;
        s_axi_arvalid  = 1'b0;
        s_axi_rready   = 1'b1;
        polarity_of[0] = periph_pkg::MODE_RST[1];
        polarity_of[1] = periph_pkg::MODE_RST[1];
        load_vectors();
        repeat (10) @(posedge S_AXI_ACLK);
        #1;
        S_AXI_ARESETN = 1'b1;
        next_cycle();
        check_count("handshake and pwm outputs after reset", 0,
                    int'({s_axi_awready, s_axi_wready, s_axi_arready, s_axi_bvalid,
                          s_axi_rvalid, pwm_out0, pwm_out1}));
        foreach (vectors[i]) begin
            run_vector(vectors[i]);
        end
        $display("sim passed");
        $finish;
    end

endmodule

/* design/periph_top.sv */
`timescale 1ns/1ns

module periph_top #(
    parameter int DATA_W = periph_pkg::DATA_W,
    parameter int ADDR_W = periph_pkg::ADDR_W
) (
    input  logic                  S_AXI_ACLK,
    input  logic                  S_AXI_ARESETN,

    input  logic [ADDR_W-1:0]     s_axi_awaddr,
    input  logic                  s_axi_awvalid,
    output logic                  s_axi_awready,

    input  logic [DATA_W-1:0]     s_axi_wdata,
    input  logic [DATA_W/8-1:0]   s_axi_wstrb,
    input  logic                  s_axi_wvalid,
    output logic                  s_axi_wready,

    output periph_pkg::axi_resp_t s_axi_bresp,
    output logic                  s_axi_bvalid,
    input  logic                  s_axi_bready,

    input  logic [ADDR_W-1:0]     s_axi_araddr,
    input  logic                  s_axi_arvalid,
    output logic                  s_axi_arready,

    output logic [DATA_W-1:0]     s_axi_rdata,
    output periph_pkg::axi_resp_t s_axi_rresp,
    output logic                  s_axi_rvalid,
    input  logic                  s_axi_rready,

    output logic                  pwm_out0,
    output logic                  pwm_out1
);

    logic              wr_en;
    logic [ADDR_W-1:0] wr_addr;
    logic [DATA_W-1:0] wr_data;
    logic [ADDR_W-1:0] rd_addr;
    logic [DATA_W-1:0] rd_data;
    logic [DATA_W-1:0] rd_data0;
    logic [DATA_W-1:0] rd_data1;

    assign rd_data = rd_data0 | rd_data1; // Unselected banks return zero.

    axi_lite_slave #(
        .DATA_W (DATA_W),
        .ADDR_W (ADDR_W)
    ) u_axi_lite_slave (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wstrb   (s_axi_wstrb),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .rd_en         (),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data)
    );

    pwm_regs #(
        .BASE   (periph_pkg::PWM0_BASE),
        .DATA_W (DATA_W),
        .ADDR_W (ADDR_W)
    ) u_pwm_regs0 (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data0),
        .pwm_out       (pwm_out0)
    );

    pwm_regs #(
        .BASE   (periph_pkg::PWM1_BASE),
        .DATA_W (DATA_W),
        .ADDR_W (ADDR_W)
    ) u_pwm_regs1 (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data1),
        .pwm_out       (pwm_out1)
    );

endmodule

/* design/pwm_regs.sv */
`timescale 1ns/1ns

module pwm_regs #(
    parameter logic [3:0] BASE   = periph_pkg::PWM0_BASE,
    parameter int          DATA_W = 32,
    parameter int          ADDR_W = 12
) (
    input  logic              S_AXI_ACLK,
    input  logic              S_AXI_ARESETN,
    input  logic              wr_en,
    input  logic [ADDR_W-1:0] wr_addr,
    input  logic [DATA_W-1:0] wr_data,
    input  logic [ADDR_W-1:0] rd_addr,
    output logic [DATA_W-1:0] rd_data,
    output logic              pwm_out
);

    logic [DATA_W-1:0] mode;
    logic [DATA_W-1:0] divider;
    logic [DATA_W-1:0] duty;
    logic [DATA_W-1:0] brightness;
    logic              wr_hit;
    logic              rd_hit;

    assign wr_hit = wr_en && (wr_addr[11:8] == BASE);
    assign rd_hit = (rd_addr[11:8] == BASE);

    always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
        if (!S_AXI_ARESETN) begin
            mode       <= DATA_W'(periph_pkg::MODE_RST);
            divider    <= DATA_W'(periph_pkg::DIVIDER_RST);
            duty       <= DATA_W'(periph_pkg::DUTY_RST);
            brightness <= DATA_W'(periph_pkg::BRIGHT_RST);
        end else if (wr_hit) begin
            case (wr_addr[7:2])
                periph_pkg::REG_MODE:       mode       <= wr_data;
                periph_pkg::REG_DIVIDER:    divider    <= wr_data;
                periph_pkg::REG_DUTY:       duty       <= wr_data;
                periph_pkg::REG_BRIGHTNESS: brightness <= wr_data;
                default: ; // Writes to unknown offsets are dropped.
            endcase
        end
    end

    // An unselected bank returns zero so that the top level can OR the banks together.
    always_comb begin
        rd_data = '0;
        if (rd_hit) begin
            case (rd_addr[7:2])
                periph_pkg::REG_MODE:       rd_data = mode;
                periph_pkg::REG_DIVIDER:    rd_data = divider;
                periph_pkg::REG_DUTY:       rd_data = duty;
                periph_pkg::REG_BRIGHTNESS: rd_data = brightness;
                default:                    rd_data = '0;
            endcase
        end
    end

    pwm_generator #(
        .CNT_W (DATA_W)
    ) u_pwm_generator (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .enable        (mode[0]),
        .polarity      (mode[1]),
        .divider       (divider),
        .duty          (duty),
        .brightness    (brightness[7:0]),
        .pwm_out       (pwm_out)
    );

endmodule

/* design/pwm_generator.sv */
`timescale 1ns/1ns

module pwm_generator #(
    parameter int CNT_W = 32
) (
    input  logic             S_AXI_ACLK,
    input  logic             S_AXI_ARESETN,
    input  logic             enable,
    input  logic             polarity,
    input  logic [CNT_W-1:0] divider,
    input  logic [CNT_W-1:0] duty,
    input  logic [7:0]       brightness,
    output logic             pwm_out
);

    logic [CNT_W-1:0] cnt;
    logic [CNT_W-1:0] div_q;
    logic [CNT_W-1:0] thr_q;
    logic [CNT_W-1:0] div_eff;
    logic [CNT_W+7:0] product;
    logic [CNT_W+7:0] scaled;
    logic [CNT_W-1:0] thr_next;
    logic             wrap;

    assign div_eff = (divider == '0) ? CNT_W'(1) : divider; // A zero divider acts as one.

    // Brightness is a fraction of BRIGHT_UNITY, so 128 leaves the duty as it is.
    assign product = (CNT_W + 8)'(duty) * (CNT_W + 8)'(brightness);
    assign scaled  = product / (CNT_W + 8)'(periph_pkg::BRIGHT_UNITY);

    // A threshold above the period would only mean always active.
    assign thr_next = (scaled > (CNT_W + 8)'(div_eff)) ? div_eff : scaled[CNT_W-1:0];

    // While disabled the counter sits at the wrap point and the shadows follow the registers.
    assign wrap = !enable || (cnt >= div_q - CNT_W'(1));

    always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
        if (!S_AXI_ARESETN) begin
            cnt   <= '0;
            div_q <= CNT_W'(1); // Forces a reload on the first cycle.
            thr_q <= '0;
        end else if (wrap) begin
            cnt   <= '0;
            div_q <= div_eff;
            thr_q <= thr_next;
        end else begin
            cnt <= cnt + CNT_W'(1);
        end
    end

    always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
        if (!S_AXI_ARESETN) begin
            pwm_out <= 1'b0;
        end else if (!enable) begin
            pwm_out <= polarity; // Idle level.
        end else begin
            pwm_out <= (cnt < thr_q) ? !polarity : polarity;
        end
    end

endmodule

/* design/axi_lite_slave.sv */
`timescale 1ns/1ns

module axi_lite_slave #(
    parameter int DATA_W = 32,
    parameter int ADDR_W = 12
) (
    input  logic                  S_AXI_ACLK,
    input  logic                  S_AXI_ARESETN,

    input  logic [ADDR_W-1:0]     s_axi_awaddr,
    input  logic                  s_axi_awvalid,
    output logic                  s_axi_awready,

    input  logic [DATA_W-1:0]     s_axi_wdata,
    input  logic [DATA_W/8-1:0]   s_axi_wstrb,
    input  logic                  s_axi_wvalid,
    output logic                  s_axi_wready,

    output periph_pkg::axi_resp_t s_axi_bresp,
    output logic                  s_axi_bvalid,
    input  logic                  s_axi_bready,

    input  logic [ADDR_W-1:0]     s_axi_araddr,
    input  logic                  s_axi_arvalid,
    output logic                  s_axi_arready,

    output logic [DATA_W-1:0]     s_axi_rdata,
    output periph_pkg::axi_resp_t s_axi_rresp,
    output logic                  s_axi_rvalid,
    input  logic                  s_axi_rready,

    output logic                  wr_en,
    output logic [ADDR_W-1:0]     wr_addr,
    output logic [DATA_W-1:0]     wr_data,
    output logic                  rd_en,
    output logic [ADDR_W-1:0]     rd_addr,
    input  logic [DATA_W-1:0]     rd_data
);

    logic wr_accept;
    logic rd_accept;
    logic wr_start;
    logic rd_start;

    // A new write needs both channels valid and no response still waiting.
    assign wr_start = s_axi_awvalid && s_axi_wvalid && !s_axi_bvalid && !wr_accept;

    // Reads wait until the previous data has been taken.
    assign rd_start = s_axi_arvalid && !s_axi_rvalid && !rd_accept;

    // The acceptance cycle is also the strobe cycle on the register bus.
    assign s_axi_awready = wr_accept;
    assign s_axi_wready  = wr_accept;
    assign wr_en         = wr_accept;

    assign s_axi_arready = rd_accept;
    assign rd_en         = rd_accept;

    assign s_axi_bresp = periph_pkg::RESP_OKAY; // Writes always succeed.
    assign s_axi_rresp = periph_pkg::RESP_OKAY;

    always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
        if (!S_AXI_ARESETN) begin
            wr_accept <= 1'b0;
            rd_accept <= 1'b0;
        end else begin
            wr_accept <= wr_start; // Pulses for one cycle because wr_start drops while it is high.
            rd_accept <= rd_start;
        end
    end

    // Address and data are stable while valid is high, so they are taken a cycle early.
    always_ff @(posedge S_AXI_ACLK) begin
        if (wr_start) begin
            wr_addr <= s_axi_awaddr;
            wr_data <= s_axi_wdata;
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (rd_start) begin
            rd_addr <= s_axi_araddr; // Held until the next read is accepted.
        end
    end

    always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
        if (!S_AXI_ARESETN) begin
            s_axi_bvalid <= 1'b0;
        end else if (wr_en) begin
            s_axi_bvalid <= 1'b1;
        end else if (s_axi_bready) begin
            s_axi_bvalid <= 1'b0;
        end
    end

    always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
        if (!S_AXI_ARESETN) begin
            s_axi_rvalid <= 1'b0;
        end else if (rd_en) begin
            s_axi_rvalid <= 1'b1;
        end else if (s_axi_rready) begin
            s_axi_rvalid <= 1'b0;
        end
    end

    // The banks decode rd_addr combinationally, so rd_data is ready in the strobe cycle.
    always_ff @(posedge S_AXI_ACLK) begin
        if (rd_en) begin
            s_axi_rdata <= rd_data;
        end
    end

endmodule

/* design/periph_pkg.sv */
package periph_pkg;

    // Bus geometry.
    localparam int DATA_W = 32;
    localparam int ADDR_W = 12;

    // Channel base codes, compared against address bits 11:8.
    localparam logic [3:0] PWM0_BASE = 4'd1;
    localparam logic [3:0] PWM1_BASE = 4'd2;

    // Word offsets in address bits 7:2.
    localparam logic [5:0] REG_MODE       = 6'd0;
    localparam logic [5:0] REG_DIVIDER    = 6'd1;
    localparam logic [5:0] REG_DUTY       = 6'd2;
    localparam logic [5:0] REG_BRIGHTNESS = 6'd3;

    // Register values after reset.
    localparam logic [31:0] MODE_RST    = 32'd0;      // Disabled with polarity 0.
    localparam logic [31:0] DIVIDER_RST = 32'd100000; // 1 kHz at a 100 MHz clock.
    localparam logic [31:0] DUTY_RST    = 32'd50000;  // Half of the default period.
    localparam logic [31:0] BRIGHT_RST  = 32'd128;

    // Brightness that passes the duty through unchanged.
    localparam logic [7:0] BRIGHT_UNITY = 8'd128;

    typedef logic [1:0] axi_resp_t;

    localparam axi_resp_t RESP_OKAY = 2'b00;

endpackage
